// File: Makefile
# Verilator simulation of the serial MAC FIR
# Example: make sim BUILD_DIR=obj LOG=run.log

VERILATOR ?= verilator
TOP       ?= fir_mac_tb
FILELIST  ?= fir_mac.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= SOME TESTS FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fir_mac_tb.sv
// --------------------------------------------------
// Table-driven testbench for the serial MAC FIR
// Expected sums come from a line model run while the table is built
// Inputs driven and outputs sampled 1 ns after the rising edge
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fir_mac_tb;

  logic             i_clk;
  logic             i_rst_an;
  logic             i_ena;
  fir_pkg::sample_t i_data;
  fir_pkg::acc_t    o_data;
  logic             o_done;

  // --------------------------------------------------
  // Stimulus table and reference line
  fir_pkg::sample_t sample_tab [$];
  int               stall_tab [$];
  longint           expect_tab [$];
  longint           model_line [fir_pkg::NUM_TAPS];
  int               max_stall;
  bit               table_ready;
  int               value_errs;
  int               flow_errs;
  integer           seed;

  fir_mac_top dut_i (
    .i_clk    (i_clk),
    .i_rst_an (i_rst_an),
    .i_ena    (i_ena),
    .i_data   (i_data),
    .o_data   (o_data),
    .o_done   (o_done)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Folded sum over the current model line
  function automatic longint model_sum();
    longint acc;
    acc = 0;
    for (int p = 0; p < fir_pkg::TAP_PAIRS; p++)
    begin
      if (fir_pkg::HAS_MIDDLE && p == fir_pkg::TAP_PAIRS - 1)
        acc += longint'(fir_pkg::COEFFS[p]) * model_line[p];
      else
        acc += longint'(fir_pkg::COEFFS[p]) *
               (model_line[p] + model_line[fir_pkg::NUM_TAPS - 1 - p]);
    end
    return acc;
  endfunction

  // Expected value covers the line before the new sample enters
  task automatic add_row(input fir_pkg::sample_t sample, input int stall);
    expect_tab.push_back(model_sum());
    for (int i = fir_pkg::NUM_TAPS - 1; i > 0; i--)
      model_line[i] = model_line[i-1];
    model_line[0] = longint'(sample);
    sample_tab.push_back(sample);
    stall_tab.push_back(stall);
    if (stall > max_stall)
      max_stall = stall;
  endtask

  task automatic build_table();
    // Impulse, zeros until the whole response has passed
    add_row(fir_pkg::sample_t'(1), 0);
    for (int k = 0; k < 18; k++)
      add_row(fir_pkg::sample_t'(0), (k == 5) ? 2 : 0);
    // Negative full-scale step, longer than the line
    for (int k = 0; k < 20; k++)
      add_row(fir_pkg::sample_t'(-128), 0);
    for (int k = 0; k < 18; k++)
      add_row((k % 2 == 0) ? fir_pkg::sample_t'(127) : fir_pkg::sample_t'(-128),
              (k == 9) ? 1 : 0);
    // Random samples, a stall every seventh frame
    for (int k = 0; k < 40; k++)
      add_row(fir_pkg::sample_t'($random(seed)), (k % 7 == 3) ? (k % 4) + 1 : 0);
  endtask

  task automatic check_value(input string name, input longint got, input longint exp);
    assert (got == exp)
    else
    begin
      $display("Fail %s: got 0x%0h, expected 0x%0h at %0t ns", name,
               fir_pkg::acc_t'(got), fir_pkg::acc_t'(exp), $time);
      value_errs++;
    end
  endtask

  // --------------------------------------------------
  // One frame: load edge, then enabled steps up to the next done
  task automatic run_frame(input int idx);
    int en_cycles;
    int stalls_left;
    assert (o_done == 1'b1)
    else
    begin
      $display("Frame %0d did not start with o_done high", idx);
      flow_errs++;
    end
    i_data = sample_tab[idx];
    i_ena  = 1'b1;
    @(posedge i_clk);
    #1;
    en_cycles = 1;
    check_value("o_data", longint'(o_data), expect_tab[idx]);
    // Must be ignored away from load edges
    i_data      = ~sample_tab[idx];
    stalls_left = stall_tab[idx];
    while (!o_done && en_cycles <= fir_pkg::TAP_PAIRS)
    begin
      if (stalls_left > 0 && en_cycles == 3)
      begin
        // Mid-frame, so o_done is low and o_data holds this frame's result
        i_ena = 1'b0;
        repeat (stalls_left)
        begin
          @(posedge i_clk);
          #1;
          check_value("o_data", longint'(o_data), expect_tab[idx]);
          check_value("o_done", longint'(o_done), 0);
        end
        stalls_left = 0;
        i_ena       = 1'b1;
      end
      @(posedge i_clk);
      #1;
      en_cycles++;
      check_value("o_data", longint'(o_data), expect_tab[idx]);
    end
    assert (en_cycles == fir_pkg::TAP_PAIRS)
    else
    begin
      $display("Frame %0d took %0d enabled cycles instead of %0d", idx, en_cycles,
               fir_pkg::TAP_PAIRS);
      flow_errs++;
    end
  endtask

  initial
  begin
    i_rst_an    = 1'b0;
    i_ena       = 1'b0;
    i_data      = '0;
    value_errs  = 0;
    flow_errs   = 0;
    max_stall   = 0;
    table_ready = 1'b0;
    seed        = 32'h93b1_8369;
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
      model_line[i] = 0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst_an = 1'b1;
    // Idle after reset, the first enabled edge loads
    check_value("o_data", longint'(o_data), 0);
    check_value("o_done", longint'(o_done), 1);
    for (int r = 0; r < sample_tab.size(); r++)
      run_frame(r);
    $display("Errors: %0d value, %0d control", value_errs, flow_errs);
    if (value_errs == 0 && flow_errs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Watchdog sized from the table length and the longest stall
  initial
  begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = (longint'(sample_tab.size()) * (fir_pkg::TAP_PAIRS + max_stall + 2) + 20) * 10;
    #(limit_ns);
    $display("Watchdog expired before the last frame finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: fir_mac.f
+incdir+include
logic/fir_pkg.sv
logic/fir_sequencer.sv
logic/fir_tap_line.sv
logic/fir_preadd_mult.sv
logic/fir_accumulator.sv
logic/fir_mac_top.sv
bench/fir_mac_tb.sv

// File: include/fir_coeffs.svh
// --------------------------------------------------
// Unique coefficients of the symmetric 17-tap low-pass
// Index 0 is the outer pair, index 8 the middle tap
// Values must fit in 12-bit signed (COEFF_W)
// --------------------------------------------------
`ifndef FIR_COEFFS_SVH
`define FIR_COEFFS_SVH

// Outer taps, small negative lobe
localparam int COEFF_VAL_0 = -6;
localparam int COEFF_VAL_1 = -18;
localparam int COEFF_VAL_2 = -27;
localparam int COEFF_VAL_3 = 0;

// Main lobe towards the centre
localparam int COEFF_VAL_4 = 87;
localparam int COEFF_VAL_5 = 231;
localparam int COEFF_VAL_6 = 392;
localparam int COEFF_VAL_7 = 516;
localparam int COEFF_VAL_8 = 562;

`endif

// File: logic/fir_accumulator.sv
// --------------------------------------------------
// Running sum of products over one frame
// Done edge moves the full sum to o_data and clears it
// No rounding or saturation on the output
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fir_accumulator (
  input  wire logic           i_clk,
  input  wire logic           i_rst_an,
  input  wire logic           i_ena,
  input  wire logic           i_done,
  input  wire fir_pkg::prod_t i_product,
  output fir_pkg::acc_t       o_data
);

  fir_pkg::acc_t sum_q;
  fir_pkg::acc_t sum_next;
  fir_pkg::acc_t data_q;

  // Sign extension of the product into the sum
  assign sum_next = sum_q + fir_pkg::acc_t'(i_product);

  // --------------------------------------------------
  // Accumulator and output register
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      sum_q  <= '0;
      data_q <= '0;
    end
    else if (i_ena)
    begin
      if (i_done)
      begin
        // Last product joins the sum on its way out
        data_q <= sum_next;
        sum_q  <= '0;
      end
      else
      begin
        sum_q <= sum_next;
      end
    end
  end

  assign o_data = data_q;

  // Output only moves on an enabled done edge
  a_data_hold: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    !(i_ena && i_done) |=> $stable(o_data));

endmodule

`default_nettype wire

// File: logic/fir_mac_top.sv
// --------------------------------------------------
// Serial MAC FIR, one multiplier shared over 9 pairs
// New sample taken only while o_done and i_ena are high
// i_ena low freezes the whole filter, no back-pressure
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fir_mac_top (
  input  wire logic             i_clk,
  input  wire logic             i_rst_an,
  input  wire logic             i_ena,
  input  wire fir_pkg::sample_t i_data,
  output fir_pkg::acc_t         o_data,
  output logic                  o_done
);

  fir_pkg::sel_t    sel;
  logic             done;
  fir_pkg::sample_t tap_near;
  fir_pkg::sample_t tap_far;
  fir_pkg::prod_t   product;

  // Control
  fir_sequencer seq_i (
    .i_clk    (i_clk),
    .i_rst_an (i_rst_an),
    .i_ena    (i_ena),
    .o_sel    (sel),
    .o_done   (done)
  );

  // --------------------------------------------------
  // Datapath
  fir_tap_line tap_line_i (
    .i_clk      (i_clk),
    .i_rst_an   (i_rst_an),
    .i_ena      (i_ena),
    .i_load     (done),
    .i_data     (i_data),
    .i_sel      (sel),
    .o_tap_near (tap_near),
    .o_tap_far  (tap_far)
  );

  fir_preadd_mult preadd_mult_i (
    .i_sel      (sel),
    .i_tap_near (tap_near),
    .i_tap_far  (tap_far),
    .o_product  (product)
  );

  fir_accumulator acc_i (
    .i_clk     (i_clk),
    .i_rst_an  (i_rst_an),
    .i_ena     (i_ena),
    .i_done    (done),
    .i_product (product),
    .o_data    (o_data)
  );

  assign o_done = done;

endmodule

`default_nettype wire

// File: logic/fir_pkg.sv
// --------------------------------------------------
// Widths, tap counts and coefficients of the MAC FIR
// Fixed configuration, symmetric response only
// Needs include/ on the include path
// --------------------------------------------------
`default_nettype none

package fir_pkg;

  // --------------------------------------------------
  // Sizes
  localparam int SAMPLE_W   = 8;
  localparam int COEFF_W    = 12;
  localparam int NUM_TAPS   = 17;
  // Multiply cycles per output sample
  localparam int TAP_PAIRS  = (NUM_TAPS + 1) / 2;
  localparam bit HAS_MIDDLE = (NUM_TAPS % 2) == 1;
  localparam int SEL_W      = $clog2(TAP_PAIRS);
  localparam int PREADD_W   = SAMPLE_W + 1;
  localparam int PROD_W     = PREADD_W + COEFF_W;
  localparam int ACC_W      = SAMPLE_W + COEFF_W + NUM_TAPS;

  // --------------------------------------------------
  // Vector types
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEFF_W-1:0]  coeff_t;
  typedef logic        [SEL_W-1:0]    sel_t;
  typedef logic signed [PREADD_W-1:0] preadd_t;
  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // Sequencer states
  typedef enum logic {
    SEQ_IDLE = 1'b0,
    SEQ_RUN  = 1'b1
  } seq_state_t;

  // --------------------------------------------------
  // Coefficient table, entry 0 weights newest and oldest sample
  `include "fir_coeffs.svh"

  localparam coeff_t COEFFS [TAP_PAIRS] = '{
    coeff_t'(COEFF_VAL_0), coeff_t'(COEFF_VAL_1), coeff_t'(COEFF_VAL_2),
    coeff_t'(COEFF_VAL_3), coeff_t'(COEFF_VAL_4), coeff_t'(COEFF_VAL_5),
    coeff_t'(COEFF_VAL_6), coeff_t'(COEFF_VAL_7), coeff_t'(COEFF_VAL_8)
  };

endpackage

`default_nettype wire

// File: logic/fir_preadd_mult.sv
// --------------------------------------------------
// Pre-adder, coefficient lookup and signed multiplier
// Purely combinational
// Index outside the table gives a zero coefficient
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fir_preadd_mult (
  input  wire fir_pkg::sel_t    i_sel,
  input  wire fir_pkg::sample_t i_tap_near,
  input  wire fir_pkg::sample_t i_tap_far,
  output fir_pkg::prod_t        o_product
);

  fir_pkg::preadd_t preadd;
  fir_pkg::coeff_t  coeff;
  logic             middle_tap;

  // Odd length: last pair is the single centre tap
  assign middle_tap = fir_pkg::HAS_MIDDLE &&
                      (i_sel == fir_pkg::sel_t'(fir_pkg::TAP_PAIRS - 1));

  // --------------------------------------------------
  // Fold mirrored taps, one extra bit against overflow
  always_comb
  begin
    if (middle_tap)
      preadd = fir_pkg::preadd_t'(i_tap_near);
    else
      preadd = fir_pkg::preadd_t'(i_tap_near) + fir_pkg::preadd_t'(i_tap_far);
  end

  // Coefficient ROM
  always_comb
  begin
    if (i_sel < fir_pkg::sel_t'(fir_pkg::TAP_PAIRS))
      coeff = fir_pkg::COEFFS[i_sel];
    else
      coeff = '0;
  end

  // --------------------------------------------------
  // Full-width signed product
  assign o_product = fir_pkg::prod_t'(preadd) * fir_pkg::prod_t'(coeff);

endmodule

`default_nettype wire

// File: logic/fir_sequencer.sv
// --------------------------------------------------
// Steps the tap-pair index once per enabled cycle
// o_done is high in idle and on the last pair
// Frame length is TAP_PAIRS enabled cycles
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fir_sequencer (
  input  wire logic          i_clk,
  input  wire logic          i_rst_an,
  input  wire logic          i_ena,
  output fir_pkg::sel_t      o_sel,
  output logic               o_done
);

  fir_pkg::seq_state_t state_q;
  fir_pkg::sel_t       sel_q;
  logic                last_pair;

  assign last_pair = (sel_q == fir_pkg::sel_t'(fir_pkg::TAP_PAIRS - 1));

  // State and pair counter
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      state_q <= fir_pkg::SEQ_IDLE;
      sel_q   <= '0;
    end
    else if (i_ena)
    begin
      case (state_q)
        fir_pkg::SEQ_IDLE:
        begin
          // First enabled edge is the load edge
          state_q <= fir_pkg::SEQ_RUN;
          sel_q   <= '0;
        end
        default:
        begin
          if (last_pair)
            sel_q <= '0;
          else
            sel_q <= sel_q + fir_pkg::sel_t'(1);
        end
      endcase
    end
  end

  assign o_sel  = sel_q;
  assign o_done = (state_q == fir_pkg::SEQ_IDLE) || last_pair;

  // Counter stays inside the coefficient table
  a_sel_range: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    (state_q == fir_pkg::SEQ_RUN) |-> (sel_q <= fir_pkg::sel_t'(fir_pkg::TAP_PAIRS - 1)));

endmodule

`default_nettype wire

// File: logic/fir_tap_line.sv
// --------------------------------------------------
// Sample delay line, position 0 holds the newest sample
// Shifts only on an enabled load (done) edge
// Select above the last pair clamps to the last pair
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fir_tap_line (
  input  wire logic             i_clk,
  input  wire logic             i_rst_an,
  input  wire logic             i_ena,
  input  wire logic             i_load,
  input  wire fir_pkg::sample_t i_data,
  input  wire fir_pkg::sel_t    i_sel,
  output fir_pkg::sample_t      o_tap_near,
  output fir_pkg::sample_t      o_tap_far
);

  fir_pkg::sample_t line_q [fir_pkg::NUM_TAPS];
  fir_pkg::sel_t    sel_clamped;

  // --------------------------------------------------
  // Shift register
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
        line_q[i] <= '0;
    end
    else if (i_ena && i_load)
    begin
      line_q[0] <= i_data;
      for (int i = 1; i < fir_pkg::NUM_TAPS; i++)
        line_q[i] <= line_q[i-1];
    end
  end

  // --------------------------------------------------
  // Mirrored read ports
  always_comb
  begin
    if (i_sel > fir_pkg::sel_t'(fir_pkg::TAP_PAIRS - 1))
      sel_clamped = fir_pkg::sel_t'(fir_pkg::TAP_PAIRS - 1);
    else
      sel_clamped = i_sel;
  end

  assign o_tap_near = line_q[sel_clamped];
  // Far tap counts back from the oldest sample
  assign o_tap_far  = line_q[fir_pkg::NUM_TAPS - 1 - int'(sel_clamped)];

endmodule

`default_nettype wire
